// File: hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN = 64;
    localparam int TAG_W = 4;

    // 5-bit operation codes with room for more
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_PASS_A = 5'd2,
        ALU_PASS_B = 5'd3,
        ALU_XOR    = 5'd4,
        ALU_OR     = 5'd5,
        ALU_AND    = 5'd6,
        ALU_SLL    = 5'd7,
        ALU_SRL    = 5'd8,
        ALU_SRA    = 5'd9,
        ALU_SLT    = 5'd10,
        ALU_SLTU   = 5'd11,
        ALU_EQ     = 5'd12,
        ALU_GE     = 5'd13,
        ALU_GEU    = 5'd14,
        ALU_MUL    = 5'd15
    } alu_op_t;

    typedef enum logic {
        SEL_A_PC  = 1'b0,
        SEL_A_RS1 = 1'b1
    } sel_a_t;

    // anything other than rs2 or csr picks the immediate
    typedef enum logic [1:0] {
        SEL_B_IMM = 2'd0,
        SEL_B_RS2 = 2'd1,
        SEL_B_CSR = 2'd2
    } sel_b_t;

    typedef struct packed {
        alu_op_t           op;
        logic [TAG_W-1:0]  tag;
        logic              word;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
    } exec_req_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   result;
    } exec_res_t;

endpackage

`default_nettype wire

// File: hw/stage_link.sv
`default_nettype none

// credit-based link between two pipeline stages
// valid is a one-cycle transfer strobe, credit a one-cycle slot return
interface stage_link #(
    parameter type payload_t = logic
);

    logic     valid;
    payload_t payload;
    logic     credit;

    // upstream side spends credits
    modport sender (
        output valid,
        output payload,
        input  credit
    );

    // downstream side hands credits back as slots free up
    modport receiver (
        input  valid,
        input  payload,
        output credit
    );

endinterface

`default_nettype wire

// File: hw/shift_add_mul.sv
`default_nettype none

module shift_add_mul #(
    parameter int XLEN = 64,
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            done,
    output logic [XLEN-1:0] product
);

    localparam int STEPS = XLEN / BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic [XLEN-1:0]  acc_q;
    logic [XLEN-1:0]  mcand_q;
    logic [XLEN-1:0]  mplier_q;
    logic [CNT_W-1:0] cnt_q;
    logic             busy_q;
    logic [XLEN-1:0]  src_a;
    logic [XLEN-1:0]  src_b;
    logic [XLEN-1:0]  partial;

    // sum of the multiplicand shifted by each set bit of the chunk
    function automatic logic [XLEN-1:0] chunk_sum(input logic [XLEN-1:0] m,
                                                  input logic [BITS_PER_CYCLE-1:0] bits);
        logic [XLEN-1:0] sum;
        sum = '0;
        for (int j = 0; j < BITS_PER_CYCLE; j++) begin
            if (bits[j]) begin
                sum = sum + (m << j);
            end
        end
        return sum;
    endfunction

    // the first chunk is taken straight from the inputs
    assign src_a = start ? a : mcand_q;
    assign src_b = start ? b : mplier_q;
    assign partial = chunk_sum(src_a, src_b[BITS_PER_CYCLE-1:0]);
    assign product = acc_q;

    always_ff @(posedge clk) begin
        if (start || busy_q) begin
            acc_q <= start ? partial : acc_q + partial;
            mcand_q <= src_a << BITS_PER_CYCLE;
            mplier_q <= src_b >> BITS_PER_CYCLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
            busy_q <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                cnt_q <= CNT_W'(STEPS - 1);
                busy_q <= (STEPS > 1);
                done <= (STEPS == 1);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                // last chunk lands on this edge
                if (cnt_q == CNT_W'(1)) begin
                    busy_q <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/operand_select.sv
`default_nettype none

module operand_select #(
    parameter int IN_DEPTH = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  exec_pkg::alu_op_t             in_op,
    input  logic [exec_pkg::TAG_W-1:0]    in_tag,
    input  logic                          in_word,
    input  exec_pkg::sel_a_t              in_sel_a,
    input  exec_pkg::sel_b_t              in_sel_b,
    input  logic [exec_pkg::XLEN-1:0]     in_pc,
    input  logic [exec_pkg::XLEN-1:0]     in_rs1,
    input  logic [exec_pkg::XLEN-1:0]     in_rs2,
    input  logic [exec_pkg::XLEN-1:0]     in_csr,
    input  logic [exec_pkg::XLEN-1:0]     in_imm,
    output logic                          in_credit,
    stage_link.sender                     req
);

    localparam int XLEN = exec_pkg::XLEN;
    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);
    // alu_core holds a single request
    localparam int ALU_CREDITS = 1;
    localparam int CR_W = $clog2(ALU_CREDITS + 1);

    typedef struct packed {
        exec_pkg::alu_op_t          op;
        logic [exec_pkg::TAG_W-1:0] tag;
        logic                       word;
        exec_pkg::sel_a_t           sel_a;
        exec_pkg::sel_b_t           sel_b;
        logic [XLEN-1:0]            pc;
        logic [XLEN-1:0]            rs1;
        logic [XLEN-1:0]            rs2;
        logic [XLEN-1:0]            csr;
        logic [XLEN-1:0]            imm;
    } raw_req_t;

    raw_req_t             queue_q [IN_DEPTH];
    raw_req_t             head;
    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [CNT_W-1:0]     count_q;
    logic [CR_W-1:0]      credit_q;
    logic                 in_credit_q;
    logic                 send;
    logic [XLEN-1:0]      rs1_eff;
    exec_pkg::exec_req_t  fwd;

    assign head = queue_q[rd_ptr_q];
    assign send = (count_q != '0) && (credit_q != '0);

    // operands are formed at the head, just before forwarding
    always_comb begin
        rs1_eff = head.word ? {{(XLEN-32){1'b0}}, head.rs1[31:0]} : head.rs1;
        fwd.op = head.op;
        fwd.tag = head.tag;
        fwd.word = head.word;
        fwd.a = (head.sel_a == exec_pkg::SEL_A_RS1) ? rs1_eff : head.pc;
        case (head.sel_b)
            exec_pkg::SEL_B_RS2: fwd.b = head.rs2;
            exec_pkg::SEL_B_CSR: fwd.b = head.csr;
            default:             fwd.b = head.imm;
        endcase
    end

    assign req.valid = send;
    assign req.payload = fwd;
    assign in_credit = in_credit_q;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            queue_q[wr_ptr_q] <= '{op: in_op, tag: in_tag, word: in_word,
                                   sel_a: in_sel_a, sel_b: in_sel_b, pc: in_pc,
                                   rs1: in_rs1, rs2: in_rs2, csr: in_csr, imm: in_imm};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            credit_q <= CR_W'(ALU_CREDITS);
            in_credit_q <= 1'b0;
        end else begin
            in_credit_q <= send;
            if (in_valid) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (send) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({in_valid, send})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            case ({send, req.credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/alu_core.sv
`default_nettype none

module alu_core #(
    parameter int OUT_DEPTH = 4,
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic        clk,
    input  logic        rst,
    stage_link.receiver req,
    stage_link.sender   res
);

    localparam int XLEN = exec_pkg::XLEN;
    localparam int CR_W = $clog2(OUT_DEPTH + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MUL,
        S_HOLD
    } state_t;

    state_t                      state_q;
    logic [CR_W-1:0]             credit_q;
    logic [exec_pkg::TAG_W-1:0]  tag_q;
    exec_pkg::exec_res_t         result_q;
    logic                        res_valid_q;
    logic                        req_credit_q;
    logic                        accept;
    logic                        is_mul;
    logic                        mul_start;
    logic                        mul_done;
    logic [XLEN-1:0]             mul_product;
    logic [XLEN-1:0]             op_a;
    logic [XLEN-1:0]             op_b;
    logic [5:0]                  shamt;
    logic [XLEN-1:0]             alu_value;
    logic                        emit;

    assign op_a = req.payload.a;
    assign op_b = req.payload.b;
    assign shamt = op_b[5:0];
    assign is_mul = (req.payload.op == exec_pkg::ALU_MUL);
    assign accept = req.valid && (state_q == S_IDLE);
    // multiplier sees the operands in the accept cycle itself
    assign mul_start = accept && is_mul;

    shift_add_mul #(
        .XLEN(XLEN),
        .BITS_PER_CYCLE(BITS_PER_CYCLE)
    ) mul_inst (
        .clk(clk),
        .rst(rst),
        .start(mul_start),
        .a(op_a),
        .b(op_b),
        .done(mul_done),
        .product(mul_product)
    );

    always_comb begin
        case (req.payload.op)
            exec_pkg::ALU_ADD:    alu_value = op_a + op_b;
            exec_pkg::ALU_SUB:    alu_value = op_a - op_b;
            exec_pkg::ALU_PASS_A: alu_value = op_a;
            exec_pkg::ALU_PASS_B: alu_value = op_b;
            exec_pkg::ALU_XOR:    alu_value = op_a ^ op_b;
            exec_pkg::ALU_OR:     alu_value = op_a | op_b;
            exec_pkg::ALU_AND:    alu_value = op_a & op_b;
            exec_pkg::ALU_SLL:    alu_value = op_a << shamt;
            exec_pkg::ALU_SRL:    alu_value = op_a >> shamt;
            // word form shifts the low half arithmetically and zeroes the upper half
            exec_pkg::ALU_SRA: begin
                if (req.payload.word) begin
                    alu_value = {{(XLEN-32){1'b0}}, 32'($signed(op_a[31:0]) >>> shamt)};
                end else begin
                    alu_value = $signed(op_a) >>> shamt;
                end
            end
            exec_pkg::ALU_SLT:    alu_value = XLEN'($signed(op_a) < $signed(op_b));
            exec_pkg::ALU_SLTU:   alu_value = XLEN'(op_a < op_b);
            exec_pkg::ALU_EQ:     alu_value = XLEN'(op_a == op_b);
            exec_pkg::ALU_GE:     alu_value = XLEN'($signed(op_a) >= $signed(op_b));
            exec_pkg::ALU_GEU:    alu_value = XLEN'(op_a >= op_b);
            default:              alu_value = '0;
        endcase
    end

    // a result leaves only with a downstream credit in hand
    always_comb begin
        emit = 1'b0;
        if (credit_q != '0) begin
            case (state_q)
                S_IDLE:  emit = accept && !is_mul;
                S_MUL:   emit = mul_done;
                S_HOLD:  emit = 1'b1;
                default: emit = 1'b0;
            endcase
        end
    end

    assign res.valid = res_valid_q;
    assign res.payload = result_q;
    assign req.credit = req_credit_q;

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q <= req.payload.tag;
        end
        if (accept && !is_mul) begin
            result_q <= '{tag: req.payload.tag, result: alu_value};
        end else if (state_q == S_MUL && mul_done) begin
            result_q <= '{tag: tag_q, result: mul_product};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            credit_q <= CR_W'(OUT_DEPTH);
            res_valid_q <= 1'b0;
            req_credit_q <= 1'b0;
        end else begin
            res_valid_q <= emit;
            // upstream slot frees once the result is gone
            req_credit_q <= emit;
            case ({emit, res.credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
            case (state_q)
                S_IDLE: begin
                    if (accept && is_mul) begin
                        state_q <= S_MUL;
                    end else if (accept && !emit) begin
                        state_q <= S_HOLD;
                    end
                end
                S_MUL: begin
                    if (mul_done) begin
                        state_q <= emit ? S_IDLE : S_HOLD;
                    end
                end
                S_HOLD: begin
                    if (emit) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/result_fifo.sv
`default_nettype none

module result_fifo #(
    parameter int OUT_DEPTH = 4,
    parameter int CONSUMER_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    stage_link.receiver                res,
    output logic                       out_valid,
    output logic [exec_pkg::TAG_W-1:0] out_tag,
    output logic [exec_pkg::XLEN-1:0]  out_result,
    input  logic                       out_credit
);

    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);
    localparam int CR_W = $clog2(CONSUMER_CREDITS + 1);

    exec_pkg::exec_res_t mem_q [OUT_DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;
    logic [CR_W-1:0]     cons_credit_q;
    logic                res_credit_q;
    logic                pop;

    // head goes out whenever the consumer has room
    assign pop = (count_q != '0) && (cons_credit_q != '0);
    assign out_valid = pop;
    assign out_tag = mem_q[rd_ptr_q].tag;
    assign out_result = mem_q[rd_ptr_q].result;
    assign res.credit = res_credit_q;

    always_ff @(posedge clk) begin
        if (res.valid) begin
            mem_q[wr_ptr_q] <= res.payload;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            cons_credit_q <= CR_W'(CONSUMER_CREDITS);
            res_credit_q <= 1'b0;
        end else begin
            res_credit_q <= pop;
            if (res.valid) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({res.valid, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            case ({pop, out_credit})
                2'b10:   cons_credit_q <= cons_credit_q - 1'b1;
                2'b01:   cons_credit_q <= cons_credit_q + 1'b1;
                default: cons_credit_q <= cons_credit_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
`default_nettype none

module exec_unit #(
    parameter int IN_DEPTH = 2,
    parameter int OUT_DEPTH = 4,
    parameter int CONSUMER_CREDITS = 2,
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  exec_pkg::alu_op_t          in_op,
    input  logic [exec_pkg::TAG_W-1:0] in_tag,
    input  logic                       in_word,
    input  exec_pkg::sel_a_t           in_sel_a,
    input  exec_pkg::sel_b_t           in_sel_b,
    input  logic [exec_pkg::XLEN-1:0]  in_pc,
    input  logic [exec_pkg::XLEN-1:0]  in_rs1,
    input  logic [exec_pkg::XLEN-1:0]  in_rs2,
    input  logic [exec_pkg::XLEN-1:0]  in_csr,
    input  logic [exec_pkg::XLEN-1:0]  in_imm,
    output logic                       in_credit,
    output logic                       out_valid,
    output logic [exec_pkg::TAG_W-1:0] out_tag,
    output logic [exec_pkg::XLEN-1:0]  out_result,
    input  logic                       out_credit
);

    // stage 1 to stage 2, and stage 2 to stage 3
    stage_link #(.payload_t(exec_pkg::exec_req_t)) req_link ();
    stage_link #(.payload_t(exec_pkg::exec_res_t)) res_link ();

    operand_select #(
        .IN_DEPTH(IN_DEPTH)
    ) operand_select_inst (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_op(in_op),
        .in_tag(in_tag),
        .in_word(in_word),
        .in_sel_a(in_sel_a),
        .in_sel_b(in_sel_b),
        .in_pc(in_pc),
        .in_rs1(in_rs1),
        .in_rs2(in_rs2),
        .in_csr(in_csr),
        .in_imm(in_imm),
        .in_credit(in_credit),
        .req(req_link.sender)
    );

    // initial credit toward the FIFO equals its depth
    alu_core #(
        .OUT_DEPTH(OUT_DEPTH),
        .BITS_PER_CYCLE(BITS_PER_CYCLE)
    ) alu_core_inst (
        .clk(clk),
        .rst(rst),
        .req(req_link.receiver),
        .res(res_link.sender)
    );

    result_fifo #(
        .OUT_DEPTH(OUT_DEPTH),
        .CONSUMER_CREDITS(CONSUMER_CREDITS)
    ) result_fifo_inst (
        .clk(clk),
        .rst(rst),
        .res(res_link.receiver),
        .out_valid(out_valid),
        .out_tag(out_tag),
        .out_result(out_result),
        .out_credit(out_credit)
    );

endmodule

`default_nettype wire

// File: verification/exec_checker.sv
`default_nettype none

// compares results with the expected queue and watches both credit loops
module exec_checker #(
    parameter int IN_DEPTH = 2,
    parameter int CONSUMER_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stim_started,
    input  logic                       in_valid,
    input  logic                       in_credit,
    input  logic                       out_valid,
    input  logic [exec_pkg::TAG_W-1:0] out_tag,
    input  logic [exec_pkg::XLEN-1:0]  out_result,
    input  logic                       out_credit,
    input  logic                       exp_push,
    input  int                         exp_id,
    input  logic [exec_pkg::TAG_W-1:0] exp_tag,
    input  logic [exec_pkg::XLEN-1:0]  exp_value,
    input  int                         exp_total,
    output int                         pass_count,
    output int                         fail_count,
    output logic                       all_done
);
    timeunit 1ns;
    timeprecision 100ps;

    int                         id_q [$];
    logic [exec_pkg::TAG_W-1:0] tag_q [$];
    logic [exec_pkg::XLEN-1:0]  value_q [$];
    int                         checked = 0;
    int                         test_ok = 0;
    int                         test_bad = 0;
    // operations the DUT holds on behalf of the sender
    int                         in_held = 0;
    int                         cons_credits = 0;

    assign all_done = (exp_total > 0) && (checked >= exp_total);

    always @(posedge exp_push) begin
        id_q.push_back(exp_id);
        tag_q.push_back(exp_tag);
        value_q.push_back(exp_value);
    end

    task automatic protocol_error(input string what);
        $display("error at %0d ns: %s", $time, what);
        fail_count++;
    endtask

    task automatic compare_result();
        int                         id;
        logic [exec_pkg::TAG_W-1:0] tag;
        logic [exec_pkg::XLEN-1:0]  value;
        if (id_q.size() == 0) begin
            protocol_error($sformatf("extra result with tag %0h, none was outstanding", out_tag));
        end else begin
            id = id_q.pop_front();
            tag = tag_q.pop_front();
            value = value_q.pop_front();
            checked++;
            if (out_tag !== tag || out_result !== value) begin
                $display("FAILED at %0d ns: test %0d tag %0h expected %h, got tag %0h result %h",
                         $time, id, tag, value, out_tag, out_result);
                fail_count++;
                test_bad++;
            end else begin
                pass_count++;
                test_ok++;
            end
            // last entry of this test id
            if (id_q.size() == 0 || id_q[0] != id) begin
                $display("test %0d finished: %0d matched, %0d mismatched", id, test_ok, test_bad);
                test_ok = 0;
                test_bad = 0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            in_held = 0;
            cons_credits = CONSUMER_CREDITS;
        end else begin
            if (!stim_started && (out_valid || in_credit)) begin
                protocol_error("DUT output went active before any operation was sent");
            end
            in_held = in_held + int'(in_valid) - int'(in_credit);
            if (in_held > IN_DEPTH) begin
                protocol_error("more operations in flight than input credits allow");
            end
            if (in_held < 0) begin
                protocol_error("input credit returned with nothing in flight");
            end
            // a credit returned this cycle is usable only from the next one
            if (out_valid) begin
                if (cons_credits == 0) begin
                    protocol_error("out_valid raised without a consumer credit");
                end
                cons_credits--;
                compare_result();
            end
            if (out_credit) begin
                cons_credits++;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/exec_unit_tb.sv
`default_nettype none

module exec_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IN_DEPTH = 2;
    localparam int OUT_DEPTH = 4;
    localparam int CONSUMER_CREDITS = 2;
    localparam int BITS_PER_CYCLE = 2;
    localparam int CLK_PERIOD = 8;
    localparam int DRIVE_DELAY = 1;
    localparam int MAX_OPS = 64;
    localparam int XLEN = exec_pkg::XLEN;
    localparam int TAG_W = exec_pkg::TAG_W;

    // one line of the golden file
    typedef struct packed {
        int               id;
        logic [4:0]       op;
        logic [TAG_W-1:0] tag;
        logic             word;
        logic             sel_a;
        logic [1:0]       sel_b;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  rs1;
        logic [XLEN-1:0]  rs2;
        logic [XLEN-1:0]  csr;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  expected;
    } golden_t;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               in_valid;
    exec_pkg::alu_op_t  in_op;
    logic [TAG_W-1:0]   in_tag;
    logic               in_word;
    exec_pkg::sel_a_t   in_sel_a;
    exec_pkg::sel_b_t   in_sel_b;
    logic [XLEN-1:0]    in_pc;
    logic [XLEN-1:0]    in_rs1;
    logic [XLEN-1:0]    in_rs2;
    logic [XLEN-1:0]    in_csr;
    logic [XLEN-1:0]    in_imm;
    logic               in_credit;
    logic               out_valid;
    logic [TAG_W-1:0]   out_tag;
    logic [XLEN-1:0]    out_result;
    logic               out_credit;

    golden_t            ops [MAX_OPS];
    int                 n_ops = 0;
    int                 issued = 0;
    int                 returned = 0;
    // results taken in but not yet credited back
    int                 held = 0;
    integer             seed = 32'h928f_f029;
    logic               stim_started = 1'b0;
    logic               exp_push = 1'b0;
    int                 exp_id = 0;
    logic [TAG_W-1:0]   exp_tag = '0;
    logic [XLEN-1:0]    exp_value = '0;
    int                 exp_total = 0;
    int                 pass_count;
    int                 fail_count;
    logic               all_done;

    always #(CLK_PERIOD / 2) clk = ~clk;

    exec_unit #(
        .IN_DEPTH(IN_DEPTH),
        .OUT_DEPTH(OUT_DEPTH),
        .CONSUMER_CREDITS(CONSUMER_CREDITS),
        .BITS_PER_CYCLE(BITS_PER_CYCLE)
    ) exec_unit_inst (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_op(in_op),
        .in_tag(in_tag),
        .in_word(in_word),
        .in_sel_a(in_sel_a),
        .in_sel_b(in_sel_b),
        .in_pc(in_pc),
        .in_rs1(in_rs1),
        .in_rs2(in_rs2),
        .in_csr(in_csr),
        .in_imm(in_imm),
        .in_credit(in_credit),
        .out_valid(out_valid),
        .out_tag(out_tag),
        .out_result(out_result),
        .out_credit(out_credit)
    );

    exec_checker #(
        .IN_DEPTH(IN_DEPTH),
        .CONSUMER_CREDITS(CONSUMER_CREDITS)
    ) exec_checker (
        .clk(clk),
        .rst(rst),
        .stim_started(stim_started),
        .in_valid(in_valid),
        .in_credit(in_credit),
        .out_valid(out_valid),
        .out_tag(out_tag),
        .out_result(out_result),
        .out_credit(out_credit),
        .exp_push(exp_push),
        .exp_id(exp_id),
        .exp_tag(exp_tag),
        .exp_value(exp_value),
        .exp_total(exp_total),
        .pass_count(pass_count),
        .fail_count(fail_count),
        .all_done(all_done)
    );

    // values settle before the strobe rises
    task automatic push_expected(input golden_t g);
        exp_id = g.id;
        exp_tag = g.tag;
        exp_value = g.expected;
        #1;
        exp_push = 1'b1;
        #1;
        exp_push = 1'b0;
    endtask

    task automatic load_golden();
        int               fd;
        int               fields;
        string            line;
        int               id;
        logic [4:0]       op;
        logic [TAG_W-1:0] tag;
        logic             word;
        logic             sel_a;
        logic [1:0]       sel_b;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  rs1;
        logic [XLEN-1:0]  rs2;
        logic [XLEN-1:0]  csr;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  expected;
        fd = $fopen("verification/exec_golden.hex", "r");
        if (fd == 0) begin
            $display("could not open verification/exec_golden.hex");
        end else begin
            while ($fgets(line, fd) != 0 && n_ops < MAX_OPS) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", id, op, tag,
                                 word, sel_a, sel_b, pc, rs1, rs2, csr, imm, expected);
                // comment lines scan no fields
                if (fields == 12) begin
                    ops[n_ops] = '{id: id, op: op, tag: tag, word: word, sel_a: sel_a,
                                   sel_b: sel_b, pc: pc, rs1: rs1, rs2: rs2, csr: csr,
                                   imm: imm, expected: expected};
                    push_expected(ops[n_ops]);
                    n_ops++;
                end
            end
            $fclose(fd);
        end
    endtask

    // called 1 ns after an edge, returns at the same point of a later cycle
    task automatic issue_op(input golden_t g);
        while (issued - returned >= IN_DEPTH) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        in_op = exec_pkg::alu_op_t'(g.op);
        in_tag = g.tag;
        in_word = g.word;
        in_sel_a = exec_pkg::sel_a_t'(g.sel_a);
        in_sel_b = exec_pkg::sel_b_t'(g.sel_b);
        in_pc = g.pc;
        in_rs1 = g.rs1;
        in_rs2 = g.rs2;
        in_csr = g.csr;
        in_imm = g.imm;
        in_valid = 1'b1;
        stim_started = 1'b1;
        issued++;
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst && in_credit) begin
            returned++;
        end
    end

    initial begin : reset_seq
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
    end

    // consumer hands slots back at random
    initial begin : consumer
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && out_valid) begin
                held++;
            end
            #DRIVE_DELAY;
            if (held > 0 && ($random(seed) % 2) != 0) begin
                out_credit = 1'b1;
                held--;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (exp_total > 0);
        // a mul takes 33 cycles so 40 per op leaves room for back-pressure
        limit = (exp_total * 40 + 100) * CLK_PERIOD;
        #(limit);
        $display("timeout after %0d ns, not every expected result arrived", limit);
        $display("test failed");
        $finish;
    end

    initial begin : main
        in_valid = 1'b0;
        in_op = exec_pkg::ALU_ADD;
        in_tag = '0;
        in_word = 1'b0;
        in_sel_a = exec_pkg::SEL_A_PC;
        in_sel_b = exec_pkg::SEL_B_IMM;
        in_pc = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_csr = '0;
        in_imm = '0;
        load_golden();
        exp_total = n_ops;
        if (n_ops == 0) begin
            $display("no operations were read from the golden file");
            $display("test failed");
            $finish;
        end else begin
            wait (rst == 1'b0);
            // idle gap where outputs must stay quiet
            repeat (5) @(posedge clk);
            #DRIVE_DELAY;
            for (int i = 0; i < n_ops; i++) begin
                issue_op(ops[i]);
            end
            wait (all_done);
            // late duplicates would show up here
            repeat (20) @(posedge clk);
            $display("results: %0d matched, %0d errors", pass_count, fail_count);
            if (fail_count == 0 && pass_count == n_ops) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
hw/exec_pkg.sv
hw/stage_link.sv
hw/shift_add_mul.sv
hw/operand_select.sv
hw/alu_core.sv
hw/result_fifo.sv
hw/exec_unit.sv
verification/exec_checker.sv
verification/exec_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module exec_unit_tb \
    -Mdir "$BUILD_DIR" -o exec_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/exec_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verification/exec_golden.hex
// columns: test id, op, tag, word, sel_a, sel_b, pc, rs1, rs2, csr, imm, expected result
// all hex, op codes as in exec_pkg::alu_op_t, sel_a 0 pc 1 rs1, sel_b 0 imm 1 rs2 2 csr
1 0 0 0 0 1 1000 5 24 7 3 1024
1 1 1 0 1 0 0 100 0 0 1 ff
1 4 2 0 1 2 0 ffff0000ffff0000 0 0f0f0f0f0f0f0f0f 0 f0f00f0ff0f00f0f
1 5 3 0 0 0 8000000000000000 0 0 0 1 8000000000000001
1 6 4 0 1 1 0 123456789abcdef0 ff00ff00ff00ff00 0 0 120056009a00de00
1 2 5 0 0 2 abc 9 0 55 0 abc
1 3 6 0 1 2 0 1 0 deadbeef 0 deadbeef
2 7 7 0 1 0 0 1 0 0 43 8
2 8 8 0 1 1 0 8000000000000000 7f 0 0 1
2 9 9 0 1 0 0 8000000000000000 0 0 4 f800000000000000
2 9 a 1 1 0 0 ffffffff80000000 0 0 4 f8000000
2 0 b 1 1 0 0 aaaaaaaaffffffff 0 0 1 100000000
3 a c 0 1 1 0 ffffffffffffffff 1 0 0 1
3 b d 0 1 1 0 ffffffffffffffff 1 0 0 0
3 c e 0 1 1 0 77 77 0 0 1
3 d f 0 1 1 0 ffffffffffffffff 0 0 0 0
3 e 0 0 1 1 0 ffffffffffffffff 0 0 0 1
4 f 1 0 1 1 0 3 5 0 0 f
4 0 2 0 1 0 0 10 0 0 20 30
4 f 3 0 1 1 0 ffffffffffffffff ffffffffffffffff 0 0 1
4 f 4 0 1 1 0 100000000 100000003 0 0 300000000
4 1 5 0 1 1 0 5 7 0 0 fffffffffffffffe
5 3 6 0 0 0 0 0 0 0 11 11
5 3 7 0 0 1 0 0 22 0 0 22
5 3 8 0 0 2 0 0 0 33 0 33
5 3 9 0 0 0 0 0 0 0 44 44
